/* all.f */
+incdir+design
design/gf_pkg.sv
design/cs_pkg.sv
design/gf_mult.sv
design/cs_pe.sv
design/cs_pe_array.sv
design/cs_sigma_stepper.sv
design/cs_root_collector.sv
design/chien_top.sv
sim/tb_clock_gen.sv
sim/tb_chien_top.sv

/* design/chien_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cs_consts.svh"

module chien_top (
    input  wire logic           i_clk,
    input  wire logic           i_rst_n,
    input  wire logic           i_start,
    input  wire cs_pkg::sigma_t i_sigma,
    output cs_pkg::cs_result_t  o_result,
    output logic                o_valid
);

    cs_pkg::sigma_t     cur_sigma;
    cs_pkg::pass_e      cur_pass;
    logic [1:0]         degree;
    logic [`CS_PAR-1:0] roots;
    cs_pkg::pass_e      roots_pass;

    // coefficient registers and pass sequencing
    cs_sigma_stepper u_stepper (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_sigma  (i_sigma),
        .o_sigma  (cur_sigma),
        .o_pass   (cur_pass),
        .o_degree (degree)
    );

    cs_pe_array u_pe_array (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_sigma (cur_sigma),
        .i_pass  (cur_pass),
        .o_roots (roots),
        .o_pass  (roots_pass)
    );

    cs_root_collector u_collector (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_roots  (roots),
        .i_pass   (roots_pass),
        .i_degree (degree),     // held since start
        .o_result (o_result),
        .o_valid  (o_valid)
    );

endmodule

`default_nettype wire

/* design/cs_consts.svh */
`ifndef CS_CONSTS_SVH
`define CS_CONSTS_SVH

// GF(2^8) field parameters
`define CS_M        8
`define CS_POLY     9'h11D      // x^8 + x^4 + x^3 + x^2 + 1

// BCH(255,239) code length
`define CS_N        255

// search parallelism
`define CS_PAR      128         // positions per cycle
`define CS_NUM_PASS 2           // CS_PAR * CS_NUM_PASS must cover CS_N

// error location width
`define CS_LOC_W    8

`endif

/* design/cs_pe.sv */
`timescale 1ns/1ps
`default_nettype none

module cs_pe #(
    parameter int INDEX = 0
) (
    input  wire cs_pkg::sigma_t i_sigma,
    output logic                o_is_root
);

    localparam gf_pkg::gf_elem_t C1 = gf_pkg::gf_pow(-INDEX);
    localparam gf_pkg::gf_elem_t C2 = gf_pkg::gf_pow(-2 * INDEX);

    gf_pkg::gf_elem_t term1;
    gf_pkg::gf_elem_t term2;

    gf_mult u_mult1 (
        .i_a       (i_sigma.s1),
        .i_b       (C1),
        .o_product (term1)
    );

    gf_mult u_mult2 (
        .i_a       (i_sigma.s2),
        .i_b       (C2),
        .o_product (term2)
    );

    assign o_is_root = ((i_sigma.s0 ^ term1 ^ term2) == '0);

endmodule

`default_nettype wire

/* design/cs_pe_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cs_consts.svh"

module cs_pe_array (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire cs_pkg::sigma_t    i_sigma,
    input  wire cs_pkg::pass_e     i_pass,
    output logic [`CS_PAR-1:0]     o_roots,
    output cs_pkg::pass_e          o_pass
);

    logic [`CS_PAR-1:0] is_root;
    logic [`CS_PAR-1:0] in_range0;
    logic [`CS_PAR-1:0] in_range1;
    logic [`CS_PAR-1:0] mask;
    logic [`CS_PAR-1:0] roots_q;
    cs_pkg::pass_e      pass_q;

    for (genvar k = 0; k < `CS_PAR; k++) begin : g_pe
        cs_pe #(
            .INDEX (k)
        ) u_pe (
            .i_sigma   (i_sigma),
            .o_is_root (is_root[k])
        );

        assign in_range0[k] = (k < `CS_N);
        assign in_range1[k] = ((`CS_PAR + k) < `CS_N);   // drops PE 127 in pass 1
    end

    always_comb begin
        case (i_pass)
            cs_pkg::PASS_0: mask = in_range0;
            cs_pkg::PASS_1: mask = in_range1;
            default:        mask = '0;
        endcase
    end

    always_ff @(posedge i_clk) begin
        roots_q <= is_root & mask;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pass_q <= cs_pkg::PASS_IDLE;
        end else begin
            pass_q <= i_pass;    // tag travels with the vector
        end
    end

    assign o_roots = roots_q;
    assign o_pass  = pass_q;

endmodule

`default_nettype wire

/* design/cs_pkg.sv */
`default_nettype none

`include "cs_consts.svh"

package cs_pkg;

    // error locator polynomial s0 + s1*x + s2*x^2
    typedef struct packed {
        gf_pkg::gf_elem_t s0;
        gf_pkg::gf_elem_t s1;
        gf_pkg::gf_elem_t s2;
    } sigma_t;

    typedef struct packed {
        logic [`CS_LOC_W-1:0] loc0;    // smallest root position
        logic [`CS_LOC_W-1:0] loc1;
        logic [1:0]           num;     // saturates at 3
        logic                 correct;
    } cs_result_t;

    typedef enum logic [1:0] {
        PASS_IDLE,
        PASS_0,
        PASS_1
    } pass_e;

endpackage

`default_nettype wire

/* design/cs_root_collector.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cs_consts.svh"

module cs_root_collector (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire logic [`CS_PAR-1:0] i_roots,
    input  wire cs_pkg::pass_e     i_pass,
    input  wire logic [1:0]        i_degree,
    output cs_pkg::cs_result_t     o_result,
    output logic                   o_valid
);

    localparam int IDX_W = $clog2(`CS_PAR);

    logic [IDX_W-1:0]     first_idx;
    logic [IDX_W-1:0]     second_idx;
    logic [1:0]           found;
    logic [`CS_LOC_W-1:0] base;
    logic [`CS_LOC_W-1:0] new_loc0;
    logic [`CS_LOC_W-1:0] new_loc1;
    logic [`CS_LOC_W-1:0] acc_loc0;
    logic [`CS_LOC_W-1:0] acc_loc1;
    logic [1:0]           acc_num;
    logic [`CS_LOC_W-1:0] old_loc0;
    logic [`CS_LOC_W-1:0] old_loc1;
    logic [1:0]           old_num;
    logic [`CS_LOC_W-1:0] mrg_loc0;
    logic [`CS_LOC_W-1:0] mrg_loc1;
    logic [1:0]           mrg_num;
    logic [2:0]           sum;
    cs_pkg::cs_result_t   result_q;
    logic                 valid_q;

    // lowest two set bits plus a saturating popcount
    always_comb begin
        first_idx  = '0;
        second_idx = '0;
        found      = 2'd0;
        for (int i = 0; i < `CS_PAR; i++) begin
            if (i_roots[i]) begin
                if (found == 2'd0) begin
                    first_idx = IDX_W'(i);
                end else if (found == 2'd1) begin
                    second_idx = IDX_W'(i);
                end
                if (found != 2'd3) begin
                    found = found + 2'd1;
                end
            end
        end
    end

    assign base     = (i_pass == cs_pkg::PASS_1) ? `CS_LOC_W'(`CS_PAR) : '0;
    assign new_loc0 = (found != 2'd0) ? base + `CS_LOC_W'(first_idx) : '0;
    assign new_loc1 = (found >= 2'd2) ? base + `CS_LOC_W'(second_idx) : '0;

    // pass 0 starts from an empty list
    assign old_loc0 = (i_pass == cs_pkg::PASS_0) ? '0 : acc_loc0;
    assign old_loc1 = (i_pass == cs_pkg::PASS_0) ? '0 : acc_loc1;
    assign old_num  = (i_pass == cs_pkg::PASS_0) ? 2'd0 : acc_num;

    // new positions always lie above stored ones
    always_comb begin
        case (old_num)
            2'd0: begin
                mrg_loc0 = new_loc0;
                mrg_loc1 = new_loc1;
            end
            2'd1: begin
                mrg_loc0 = old_loc0;
                mrg_loc1 = new_loc0;
            end
            default: begin
                mrg_loc0 = old_loc0;
                mrg_loc1 = old_loc1;
            end
        endcase
        sum     = {1'b0, old_num} + {1'b0, found};
        mrg_num = (sum > 3'd3) ? 2'd3 : sum[1:0];
    end

    always_ff @(posedge i_clk) begin
        if (i_pass != cs_pkg::PASS_IDLE) begin
            acc_loc0 <= mrg_loc0;
            acc_loc1 <= mrg_loc1;
            acc_num  <= mrg_num;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            result_q <= '0;
            valid_q  <= 1'b0;
        end else begin
            valid_q <= (i_pass == cs_pkg::PASS_1);
            if (i_pass == cs_pkg::PASS_1) begin
                result_q.loc0    <= mrg_loc0;
                result_q.loc1    <= mrg_loc1;
                result_q.num     <= mrg_num;
                result_q.correct <= (mrg_num == i_degree);
            end
        end
    end

    assign o_result = result_q;
    assign o_valid  = valid_q;

endmodule

`default_nettype wire

/* design/cs_sigma_stepper.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cs_consts.svh"

module cs_sigma_stepper (
    input  wire logic           i_clk,
    input  wire logic           i_rst_n,
    input  wire logic           i_start,
    input  wire cs_pkg::sigma_t i_sigma,
    output cs_pkg::sigma_t      o_sigma,
    output cs_pkg::pass_e       o_pass,
    output logic [1:0]          o_degree
);

    // shift evaluation window by CS_PAR positions
    localparam gf_pkg::gf_elem_t STEP1 = gf_pkg::gf_pow(-`CS_PAR);
    localparam gf_pkg::gf_elem_t STEP2 = gf_pkg::gf_pow(-2 * `CS_PAR);

    cs_pkg::pass_e    state_q;
    cs_pkg::sigma_t   sigma_q;
    logic [1:0]       degree_q;
    gf_pkg::gf_elem_t next_s1;
    gf_pkg::gf_elem_t next_s2;

    gf_mult u_step1 (
        .i_a       (sigma_q.s1),
        .i_b       (STEP1),
        .o_product (next_s1)
    );

    gf_mult u_step2 (
        .i_a       (sigma_q.s2),
        .i_b       (STEP2),
        .o_product (next_s2)
    );

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q  <= cs_pkg::PASS_IDLE;
            degree_q <= 2'd0;
        end else if (i_start) begin
            state_q <= cs_pkg::PASS_0;    // start also restarts a running search
            if (i_sigma.s2 != '0) begin
                degree_q <= 2'd2;
            end else if (i_sigma.s1 != '0) begin
                degree_q <= 2'd1;
            end else begin
                degree_q <= 2'd0;
            end
        end else begin
            case (state_q)
                cs_pkg::PASS_0: state_q <= cs_pkg::PASS_1;
                default:        state_q <= cs_pkg::PASS_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_start) begin
            sigma_q <= i_sigma;
        end else if (state_q == cs_pkg::PASS_0) begin
            sigma_q.s1 <= next_s1;    // s0 unchanged between passes
            sigma_q.s2 <= next_s2;
        end
    end

    assign o_sigma  = sigma_q;
    assign o_pass   = state_q;
    assign o_degree = degree_q;

endmodule

`default_nettype wire

/* design/gf_mult.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cs_consts.svh"

module gf_mult (
    input  wire gf_pkg::gf_elem_t i_a,
    input  wire gf_pkg::gf_elem_t i_b,
    output gf_pkg::gf_elem_t      o_product
);

    gf_pkg::gf_elem_t acc;

    // horner style, msb of i_b first
    always_comb begin
        acc = '0;
        for (int i = `CS_M - 1; i >= 0; i--) begin
            acc = gf_pkg::gf_xtime(acc);
            if (i_b[i]) begin
                acc = acc ^ i_a;
            end
        end
    end

    assign o_product = acc;

endmodule

`default_nettype wire

/* design/gf_pkg.sv */
`default_nettype none

`include "cs_consts.svh"

package gf_pkg;

    typedef logic [`CS_M-1:0] gf_elem_t;

    localparam int GF_ORDER = (1 << `CS_M) - 1;    // multiplicative group size
    localparam gf_elem_t GF_POLY_LOW = gf_elem_t'(`CS_POLY);

    // multiply by alpha, one reduction step
    function automatic gf_elem_t gf_xtime(gf_elem_t a);
        gf_elem_t shifted;
        shifted = {a[`CS_M-2:0], 1'b0};
        if (a[`CS_M-1]) begin
            shifted = shifted ^ GF_POLY_LOW;
        end
        return shifted;
    endfunction

    // alpha^p, negative powers wrap around the group order
    function automatic gf_elem_t gf_pow(int p);
        int e;
        gf_elem_t r;
        e = p % GF_ORDER;
        if (e < 0) begin
            e = e + GF_ORDER;
        end
        r = gf_elem_t'(1);
        for (int i = 0; i < e; i++) begin
            r = gf_xtime(r);
        end
        return r;
    endfunction

endpackage

`default_nettype wire

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_chien_top -f all.f -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sim/tb_chien_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cs_consts.svh"

module tb_chien_top;

    localparam int WAIT_LIMIT = 20;    // cycles before a wait gives up

    logic               clk;
    logic               rst_n;
    logic               start;
    cs_pkg::sigma_t     sigma;
    cs_pkg::cs_result_t result;
    logic               valid;
    logic [7:0]         alpha_pow [0:`CS_N-1];

    tb_clock_gen #(.PERIOD(40), .RST_CYCLES(2)) u_clock_gen (.o_clk(clk), .o_rst_n(rst_n));

    chien_top chien_top_inst (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_start  (start),
        .i_sigma  (sigma),
        .o_result (result),
        .o_valid  (valid)
    );

    // lsb first shift and add reduced by x^8 + x^4 + x^3 + x^2 + 1
    function automatic logic [7:0] field_mul(logic [7:0] a, logic [7:0] b);
        logic [7:0] p;
        logic [7:0] aa;
        p  = 8'h00;
        aa = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                p = p ^ aa;
            end
            aa = aa[7] ? ({aa[6:0], 1'b0} ^ 8'h1D) : {aa[6:0], 1'b0};
        end
        return p;
    endfunction

    // brute force over every position of the code
    function automatic cs_pkg::cs_result_t ref_result(cs_pkg::sigma_t s);
        cs_pkg::cs_result_t r;
        logic [7:0]         x;
        logic [1:0]         deg;
        int                 cnt;
        r   = '0;
        cnt = 0;
        for (int j = 0; j < `CS_N; j++) begin
            x = alpha_pow[(`CS_N - j) % `CS_N];    // alpha^-j
            if ((s.s0 ^ field_mul(s.s1, x) ^ field_mul(s.s2, field_mul(x, x))) == 8'h00) begin
                if (cnt == 0) begin
                    r.loc0 = 8'(j);
                end else if (cnt == 1) begin
                    r.loc1 = 8'(j);
                end
                cnt++;
            end
        end
        if (s.s2 != 8'h00) begin
            deg = 2'd2;
        end else if (s.s1 != 8'h00) begin
            deg = 2'd1;
        end else begin
            deg = 2'd0;
        end
        r.num     = (cnt > 3) ? 2'd3 : 2'(cnt);
        r.correct = (r.num == deg);
        return r;
    endfunction

    function automatic cs_pkg::cs_result_t expect_of(int l0, int l1, int n, logic c);
        cs_pkg::cs_result_t r;
        r.loc0    = 8'(l0);
        r.loc1    = 8'(l1);
        r.num     = 2'(n);
        r.correct = c;
        return r;
    endfunction

    function automatic cs_pkg::sigma_t two_root_poly(int i, int k);
        cs_pkg::sigma_t s;
        s.s0 = 8'h01;
        s.s1 = alpha_pow[i] ^ alpha_pow[k];
        s.s2 = alpha_pow[(i + k) % `CS_N];
        return s;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_quiet(input int cycles, input cs_pkg::cs_result_t held);
        for (int c = 0; c < cycles; c++) begin
            assert (!valid && result == held) else abort_run($sformatf(
                "[ERROR] %0t: valid=%0b result=%h while idle, expected result %h",
                $time, valid, result, held));
            @(negedge clk);
        end
    endtask

    // counts edges after the start edge, checks latency, value and hold
    task automatic wait_for_valid(input cs_pkg::cs_result_t exp);
        int edges;
        edges = 0;
        while (!valid) begin
            if (edges >= WAIT_LIMIT) begin
                abort_run("timeout: o_valid never went high after a start");
            end
            @(negedge clk);
            edges++;
        end
        assert (edges == 3) else abort_run($sformatf(
            "[ERROR] %0t: o_valid came %0d edges after start, expected 3", $time, edges));
        assert (result == exp) else abort_run($sformatf(
            "[ERROR] %0t: got loc0=%0d loc1=%0d num=%0d correct=%0b, expected %0d %0d %0d %0b",
            $time, result.loc0, result.loc1, result.num, result.correct,
            exp.loc0, exp.loc1, exp.num, exp.correct));
        @(negedge clk);
        check_quiet(3, exp);
    endtask

    task automatic run_search(input cs_pkg::sigma_t s, input cs_pkg::cs_result_t exp);
        start = 1'b1;
        sigma = s;
        @(negedge clk);
        start = 1'b0;
        wait_for_valid(exp);
    endtask

    initial begin
        cs_pkg::sigma_t s;
        int             a;
        int             b;
        int             n;
        start = 1'b0;
        sigma = '0;
        void'($urandom(32'hba4b_e667));
        alpha_pow[0] = 8'h01;
        for (int i = 1; i < `CS_N; i++) begin
            alpha_pow[i] = field_mul(alpha_pow[i-1], 8'h02);
        end
        n = 0;
        @(posedge clk);
        while (rst_n !== 1'b1) begin
            if (n >= WAIT_LIMIT) begin
                abort_run("timeout: reset was never released");
            end
            @(posedge clk);
            n++;
        end
        @(negedge clk);
        check_quiet(3, '0);
        run_search('{8'h01, alpha_pow[5], 8'h00}, expect_of(5, 0, 1, 1'b1));
        run_search('{8'h01, alpha_pow[200], 8'h00}, expect_of(200, 0, 1, 1'b1));
        run_search(two_root_poly(180, 30), expect_of(30, 180, 2, 1'b1));
        run_search(two_root_poly(77, 77), ref_result(two_root_poly(77, 77)));    // double root
        run_search('0, expect_of(0, 1, 3, 1'b0));    // every position is a root
        // restart one cycle in so only the second search reports
        start = 1'b1;
        sigma = '{8'h01, alpha_pow[5], 8'h00};
        @(negedge clk);
        sigma = '{8'h01, alpha_pow[200], 8'h00};
        @(negedge clk);
        start = 1'b0;
        wait_for_valid(expect_of(200, 0, 1, 1'b1));
        for (int t = 0; t < 40; t++) begin
            a = int'($urandom % 255);
            b = int'($urandom % 255);
            case ($urandom % 4)
                0: s = 24'($urandom);
                1: s = two_root_poly(a, b);
                2: s = '{8'(a + 1), field_mul(8'(a + 1), alpha_pow[b]), 8'h00};
                default: s = '{8'($urandom), 8'($urandom % 3), 8'h00};
            endcase
            run_search(s, ref_result(s));
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 2
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);    // release away from the sampling edge
        o_rst_n = 1'b1;
    end

endmodule

`default_nettype wire
